/* sim.f */
logic/bus_pkg.sv
logic/mem_rd_if.sv
logic/read_arbiter.sv
logic/read_router.sv
logic/clint_timer.sv
logic/mem_fabric.sv
sim/mem_fabric_props.sv
sim/mem_fabric_tb.sv

/* sim/mem_fabric_tb.sv */
`timescale 1ns/100ps

module mem_fabric_tb import bus_pkg::*; ();

  localparam logic [addr_width-1:0] clint_base = 32'h0200_0000;
  localparam logic [data_width-1:0] data_key = 32'hA5C3_5A3C;  // external read data rule
  localparam int max_delay = 5;
  localparam int max_ar_wait = 2;  // extra cycles before the model takes an address
  localparam int n_rows = 11;
  localparam int cycle_limit = n_rows * (max_delay + max_ar_wait + 8) + 100;

  localparam int p_fetch = 0;
  localparam int p_lsu = 1;
  localparam int p_both = 2;  // fetch and lsu in the same cycle

  localparam int k_ext = 0;    // data is addr ^ data_key
  localparam int k_mtime = 1;  // timer low word, rising
  localparam int k_zero = 2;   // timer high word
  localparam int k_write = 3;

  typedef struct {
    int                    port;
    bit                    wr;
    logic [addr_width-1:0] addr;
    logic [id_width-1:0]   id;
    logic [size_width-1:0] size;
    int                    stall;  // cycles of rready low after rvalid
    int                    kind;
  } row_t;

  row_t rows [n_rows] = '{
    '{p_fetch, 1'b0, 32'h8000_0000, 4'd1, 3'd2, 0, k_ext},
    '{p_lsu, 1'b0, 32'h8000_0104, 4'd2, 3'd1, 0, k_ext},
    '{p_both, 1'b0, 32'h8000_0200, 4'd4, 3'd2, 0, k_ext},
    '{p_lsu, 1'b0, clint_base + mtime_lo_off, 4'd6, 3'd2, 0, k_mtime},
    '{p_fetch, 1'b0, clint_base + mtime_lo_off, 4'd7, 3'd2, 0, k_mtime},
    '{p_lsu, 1'b0, clint_base + mtime_hi_off, 4'd8, 3'd2, 0, k_zero},
    '{p_lsu, 1'b1, 32'h8000_0010, 4'd9, 3'd2, 0, k_write},
    '{p_lsu, 1'b1, 32'h8000_0023, 4'd10, 3'd0, 0, k_write},
    '{p_fetch, 1'b0, 32'h8000_0300, 4'd11, 3'd2, 5, k_ext},
    '{p_lsu, 1'b0, clint_base + mtime_lo_off, 4'd12, 3'd2, 4, k_mtime},
    '{p_lsu, 1'b1, 32'h8000_0036, 4'd3, 3'd1, 0, k_write}
  };

  // driven by the testbench
  logic clock = 1'b0;
  logic rst = 1'b1;
  logic fetch_arvalid = 1'b0, fetch_rready = 1'b0;
  logic lsu_arvalid = 1'b0, lsu_rready = 1'b0;
  logic lsu_awvalid = 1'b0, lsu_wvalid = 1'b0, lsu_wlast = 1'b0, lsu_bready = 1'b0;
  logic io_master_awready = 1'b1, io_master_wready = 1'b1, io_master_bvalid = 1'b0;
  logic io_master_arready = 1'b0, io_master_rvalid = 1'b0, io_master_rlast = 1'b0;
  logic [addr_width-1:0] fetch_araddr = '0, lsu_araddr = '0, lsu_awaddr = '0;
  logic [id_width-1:0] fetch_arid = '0, lsu_arid = '0, lsu_awid = '0;
  logic [id_width-1:0] io_master_bid = '0, io_master_rid = '0;
  logic [size_width-1:0] fetch_arsize = '0, lsu_arsize = '0, lsu_awsize = '0;
  logic [data_width-1:0] lsu_wdata = '0, io_master_rdata = '0;
  logic [strb_width-1:0] lsu_wstrb = '0;
  logic [resp_width-1:0] io_master_bresp = '0, io_master_rresp = '0;

  // driven by the dut
  logic fetch_arready, fetch_rvalid, fetch_rlast, lsu_arready, lsu_rvalid, lsu_rlast;
  logic lsu_awready, lsu_wready, lsu_bvalid;
  logic io_master_awvalid, io_master_wvalid, io_master_wlast, io_master_bready;
  logic io_master_arvalid, io_master_rready;
  logic [addr_width-1:0] io_master_awaddr, io_master_araddr;
  logic [id_width-1:0] fetch_rid, lsu_rid, lsu_bid, io_master_awid, io_master_arid;
  logic [size_width-1:0] io_master_awsize, io_master_arsize;
  logic [data_width-1:0] fetch_rdata, lsu_rdata, io_master_wdata;
  logic [strb_width-1:0] io_master_wstrb;
  logic [resp_width-1:0] fetch_rresp, lsu_rresp, lsu_bresp;

  // external slave model state
  logic                  rd_busy;
  logic [addr_width-1:0] rd_addr;
  logic [id_width-1:0]   rd_id;
  logic [size_width-1:0] rd_size;
  int                    delay_cnt;
  int                    ar_wait;
  logic                  aw_seen, w_seen;
  logic [addr_width-1:0] wr_addr;
  logic [id_width-1:0]   wr_id;
  logic [size_width-1:0] wr_size;
  logic                  wr_last;
  logic [data_width-1:0] wr_data;
  logic [strb_width-1:0] wr_strb;
  logic [data_width-1:0] mem [16];
  logic [id_width-1:0]   ar_log [$];  // ids in external address handshake order

  integer seed = 19;
  int     checks = 0;
  int     errors = 0;
  int     cycles = 0;
  mtime_u last_mtime;

  mem_fabric #(.clint_base(clint_base)) dut (.*);

  initial begin
    forever #5 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, a handshake never completed", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  // read side of the external slave, one outstanding read
  always @(posedge clock) begin
    if (rst) begin
      io_master_arready <= 1'b0;
      io_master_rvalid  <= 1'b0;
      rd_busy           <= 1'b0;
      ar_wait           <= 1;
    end else if (io_master_arvalid && io_master_arready) begin
      rd_addr           <= io_master_araddr;
      rd_id             <= io_master_arid;
      rd_size           <= io_master_arsize;
      delay_cnt         <= $unsigned($random(seed)) % (max_delay + 1);
      ar_wait           <= $unsigned($random(seed)) % (max_ar_wait + 1);
      io_master_arready <= 1'b0;
      rd_busy           <= 1'b1;
      ar_log.push_back(io_master_arid);
    end else if (rd_busy && !io_master_rvalid) begin
      if (delay_cnt == 0) begin
        io_master_rvalid <= 1'b1;
        io_master_rdata  <= rd_addr ^ data_key;
        io_master_rid    <= rd_id;
        io_master_rresp  <= resp_okay;
        io_master_rlast  <= 1'b1;
      end else begin
        delay_cnt <= delay_cnt - 1;
      end
    end else if (io_master_rvalid && io_master_rready) begin
      io_master_rvalid <= 1'b0;
      rd_busy          <= 1'b0;
    end else if (io_master_arvalid && !rd_busy) begin
      // address left waiting a few cycles
      if (ar_wait == 0) begin
        io_master_arready <= 1'b1;
      end else begin
        ar_wait <= ar_wait - 1;
      end
    end
  end

  // write side, strobed bytes land in mem
  always @(posedge clock) begin
    if (rst) begin
      aw_seen          <= 1'b0;
      w_seen           <= 1'b0;
      io_master_bvalid <= 1'b0;
    end else begin
      if (io_master_awvalid && io_master_awready) begin
        aw_seen <= 1'b1;
        wr_addr <= io_master_awaddr;
        wr_id   <= io_master_awid;
        wr_size <= io_master_awsize;
      end
      if (io_master_wvalid && io_master_wready) begin
        w_seen  <= 1'b1;
        wr_data <= io_master_wdata;
        wr_strb <= io_master_wstrb;
        wr_last <= io_master_wlast;
      end
      if (aw_seen && w_seen && !io_master_bvalid) begin
        for (int b = 0; b < strb_width; b++) begin
          if (wr_strb[b]) mem[wr_addr[5:2]][8*b +: 8] <= wr_data[8*b +: 8];
        end
        io_master_bvalid <= 1'b1;
        io_master_bid    <= wr_id;
        io_master_bresp  <= resp_okay;
        aw_seen          <= 1'b0;
        w_seen           <= 1'b0;
      end else if (io_master_bvalid && io_master_bready) begin
        io_master_bvalid <= 1'b0;
      end
    end
  end

  task automatic compare_data(input string what, input logic [data_width-1:0] got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_addr(input string what, input logic [addr_width-1:0] got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_id(input string what, input logic [id_width-1:0] got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_size(input string what, input logic [size_width-1:0] got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic compare_resp(input string what, input logic [resp_width-1:0] got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic compare_flag(input string what, input logic got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // timer must move strictly forward between reads
  task automatic compare_mtime(input string what, input mtime_u got, prev);
    checks++;
    if (!(got.count > prev.count)) begin
      errors++;
      $display("** Error at %0t: %s got %h not above %h", $time, what, got.count, prev.count);
    end
  endtask

  function automatic logic [strb_width-1:0] strb_for(input logic [size_width-1:0] size,
                                                     input logic [addr_width-1:0] addr);
    case (size)
      3'd0:    return 4'b0001 << addr[1:0];
      3'd1:    return 4'b0011 << {addr[1], 1'b0};
      default: return 4'b1111;
    endcase
  endfunction

  function automatic logic [data_width-1:0] merge_word(input logic [data_width-1:0] old, data,
                                                       input logic [strb_width-1:0] strb);
    logic [data_width-1:0] w;
    w = old;
    for (int b = 0; b < strb_width; b++) begin
      if (strb[b]) w[8*b +: 8] = data[8*b +: 8];
    end
    return w;
  endfunction

  task automatic read_port(input int port, input logic [addr_width-1:0] addr,
                           input logic [id_width-1:0] id, input logic [size_width-1:0] size,
                           input int stall, output logic [data_width-1:0] data,
                           output logic [id_width-1:0] rid, output logic [resp_width-1:0] resp,
                           output logic last);
    logic [data_width-1:0] first;
    bit                    to_lsu;
    to_lsu = (port == p_lsu);
    @(posedge clock);
    if (to_lsu) begin
      lsu_arvalid <= 1'b1;
      lsu_araddr  <= addr;
      lsu_arid    <= id;
      lsu_arsize  <= size;
    end else begin
      fetch_arvalid <= 1'b1;
      fetch_araddr  <= addr;
      fetch_arid    <= id;
      fetch_arsize  <= size;
    end
    @(posedge clock);
    while (!(to_lsu ? (lsu_arvalid && lsu_arready) : (fetch_arvalid && fetch_arready)))
      @(posedge clock);
    if (to_lsu) lsu_arvalid <= 1'b0;
    else fetch_arvalid <= 1'b0;
    while (!(to_lsu ? lsu_rvalid : fetch_rvalid))
      @(posedge clock);
    first = to_lsu ? lsu_rdata : fetch_rdata;
    repeat (stall) @(posedge clock);  // hold rready low
    if (to_lsu) lsu_rready <= 1'b1;
    else fetch_rready <= 1'b1;
    @(posedge clock);
    while (!(to_lsu ? (lsu_rvalid && lsu_rready) : (fetch_rvalid && fetch_rready)))
      @(posedge clock);
    data = to_lsu ? lsu_rdata : fetch_rdata;
    rid  = to_lsu ? lsu_rid : fetch_rid;
    resp = to_lsu ? lsu_rresp : fetch_rresp;
    last = to_lsu ? lsu_rlast : fetch_rlast;
    if (to_lsu) lsu_rready <= 1'b0;
    else fetch_rready <= 1'b0;
    compare_data("rdata held under back-pressure", data, first);
  endtask

  task automatic write_lsu(input logic [addr_width-1:0] addr, input logic [id_width-1:0] id,
                           input logic [size_width-1:0] size, input logic [data_width-1:0] data,
                           input logic [strb_width-1:0] strb, output logic [id_width-1:0] bid,
                           output logic [resp_width-1:0] bresp);
    bit aw_ok;
    bit w_ok;
    aw_ok = 1'b0;
    w_ok  = 1'b0;
    @(posedge clock);
    lsu_awvalid <= 1'b1;
    lsu_awaddr  <= addr;
    lsu_awid    <= id;
    lsu_awsize  <= size;
    lsu_wvalid  <= 1'b1;
    lsu_wdata   <= data;
    lsu_wstrb   <= strb;
    lsu_wlast   <= 1'b1;
    while (!(aw_ok && w_ok)) begin
      @(posedge clock);
      if (lsu_awvalid && lsu_awready) begin
        aw_ok = 1'b1;
        lsu_awvalid <= 1'b0;
      end
      if (lsu_wvalid && lsu_wready) begin
        w_ok = 1'b1;
        lsu_wvalid <= 1'b0;
      end
    end
    lsu_bready <= 1'b1;
    @(posedge clock);
    while (!(lsu_bvalid && lsu_bready))
      @(posedge clock);
    bid   = lsu_bid;
    bresp = lsu_bresp;
    lsu_bready <= 1'b0;
  endtask

  task automatic check_ext(input logic [addr_width-1:0] addr, input logic [id_width-1:0] id,
                           input logic [data_width-1:0] data, input logic [id_width-1:0] rid,
                           input logic [resp_width-1:0] resp, input logic last);
    compare_data("external rdata", data, addr ^ data_key);
    compare_id("external rid", rid, id);
    compare_resp("external rresp", resp, resp_okay);
    compare_flag("external rlast", last, 1'b1);
  endtask

  task automatic run_row(input row_t row);
    logic [data_width-1:0] d0, d1, old;
    logic [id_width-1:0]   i0, i1;
    logic [resp_width-1:0] r0, r1;
    logic                  l0, l1;
    logic [strb_width-1:0] strb;
    mtime_u                cur;
    ar_log.delete();
    if (row.kind == k_write) begin
      d0   = $random(seed);
      strb = strb_for(row.size, row.addr);
      old  = mem[row.addr[5:2]];
      write_lsu(row.addr, row.id, row.size, d0, strb, i0, r0);
      compare_addr("io_master awaddr", wr_addr, row.addr);
      compare_size("io_master awsize", wr_size, row.size);
      compare_flag("io_master wlast", wr_last, 1'b1);
      compare_data("written word", mem[row.addr[5:2]], merge_word(old, d0, strb));
      compare_id("bid", i0, row.id);
      compare_resp("bresp", r0, resp_okay);
    end else if (row.port == p_both) begin
      fork
        read_port(p_lsu, row.addr, row.id, row.size, row.stall, d0, i0, r0, l0);
        read_port(p_fetch, row.addr + 16, row.id + 1, row.size, row.stall, d1, i1, r1, l1);
      join
      check_ext(row.addr, row.id, d0, i0, r0, l0);
      check_ext(row.addr + 16, row.id + 1, d1, i1, r1, l1);
      compare_size("io_master arsize", rd_size, row.size);
      compare_flag("two external address handshakes", ar_log.size() == 2, 1'b1);
      if (ar_log.size() == 2) begin
        compare_id("first granted id", ar_log[0], row.id);  // load/store wins
        compare_id("second granted id", ar_log[1], row.id + 1);
      end
    end else begin
      read_port(row.port, row.addr, row.id, row.size, row.stall, d0, i0, r0, l0);
      if (row.kind == k_ext) begin
        check_ext(row.addr, row.id, d0, i0, r0, l0);
        compare_size("io_master arsize", rd_size, row.size);
        compare_flag("one external address handshake", ar_log.size() == 1, 1'b1);
      end else begin
        compare_flag("no external address for clint", ar_log.size() == 0, 1'b1);
        compare_id("clint rid", i0, row.id);
        compare_resp("clint rresp", r0, resp_okay);
        compare_flag("clint rlast", l0, 1'b1);
        if (row.kind == k_zero) begin
          compare_data("mtime high word", d0, '0);
        end else begin
          cur.halves.hi = '0;
          cur.halves.lo = d0;
          compare_mtime("mtime low word", cur, last_mtime);
          last_mtime = cur;
        end
      end
    end
  endtask

  initial begin
    last_mtime.count = '0;
    for (int i = 0; i < 16; i++) begin
      mem[i] = 32'h1357_9BDF ^ (i * 32'h0101_0101);
    end
    repeat (3) @(posedge clock);
    rst <= 1'b0;
    foreach (rows[r]) begin
      run_row(rows[r]);
    end
    repeat (2) @(posedge clock);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* sim/mem_fabric_props.sv */
`timescale 1ns/100ps

module mem_fabric_props import bus_pkg::*; #(
  parameter logic [addr_width-1:0] clint_base = 32'h0200_0000
) (
  input logic                  clock,
  input logic                  rst,
  input logic                  io_master_arvalid,
  input logic                  io_master_arready,
  input logic [addr_width-1:0] io_master_araddr,
  input logic                  fetch_rvalid,
  input logic                  fetch_rready,
  input logic [data_width-1:0] fetch_rdata,
  input logic                  lsu_rvalid,
  input logic                  lsu_rready,
  input logic [data_width-1:0] lsu_rdata
);

  // external address held until the slave takes it
  ar_stable: assert property (@(posedge clock) disable iff (rst)
    io_master_arvalid && !io_master_arready |=> io_master_arvalid && $stable(io_master_araddr))
    else $error("io_master ar payload changed before acceptance");

  // back-pressure seen at each requester port
  fetch_r_stable: assert property (@(posedge clock) disable iff (rst)
    fetch_rvalid && !fetch_rready |=> fetch_rvalid && $stable(fetch_rdata))
    else $error("fetch read response changed while rready was low");

  lsu_r_stable: assert property (@(posedge clock) disable iff (rst)
    lsu_rvalid && !lsu_rready |=> lsu_rvalid && $stable(lsu_rdata))
    else $error("lsu read response changed while rready was low");

  // timer window never leaks to the external bus
  clint_isolated: assert property (@(posedge clock) disable iff (rst)
    io_master_arvalid |->
      (io_master_araddr < clint_base) || (io_master_araddr >= clint_base + clint_size))
    else $error("io_master_arvalid raised for an address in the clint window");

endmodule

bind mem_fabric mem_fabric_props #(.clint_base(clint_base)) u_props (
  .clock             (clock),
  .rst               (rst),
  .io_master_arvalid (io_master_arvalid),
  .io_master_arready (io_master_arready),
  .io_master_araddr  (io_master_araddr),
  .fetch_rvalid      (fetch_rvalid),
  .fetch_rready      (fetch_rready),
  .fetch_rdata       (fetch_rdata),
  .lsu_rvalid        (lsu_rvalid),
  .lsu_rready        (lsu_rready),
  .lsu_rdata         (lsu_rdata)
);

/* logic/mem_fabric.sv */
`timescale 1ns/100ps

module mem_fabric import bus_pkg::*; #(
  parameter logic [addr_width-1:0] clint_base = 32'h0200_0000
) (
  input  logic                  clock,
  input  logic                  rst,
  // fetch read port
  input  logic                  fetch_arvalid,
  output logic                  fetch_arready,
  input  logic [addr_width-1:0] fetch_araddr,
  input  logic [id_width-1:0]   fetch_arid,
  input  logic [size_width-1:0] fetch_arsize,
  output logic                  fetch_rvalid,
  input  logic                  fetch_rready,
  output logic [data_width-1:0] fetch_rdata,
  output logic [resp_width-1:0] fetch_rresp,
  output logic                  fetch_rlast,
  output logic [id_width-1:0]   fetch_rid,
  // load/store read port
  input  logic                  lsu_arvalid,
  output logic                  lsu_arready,
  input  logic [addr_width-1:0] lsu_araddr,
  input  logic [id_width-1:0]   lsu_arid,
  input  logic [size_width-1:0] lsu_arsize,
  output logic                  lsu_rvalid,
  input  logic                  lsu_rready,
  output logic [data_width-1:0] lsu_rdata,
  output logic [resp_width-1:0] lsu_rresp,
  output logic                  lsu_rlast,
  output logic [id_width-1:0]   lsu_rid,
  // load/store write port
  input  logic                  lsu_awvalid,
  output logic                  lsu_awready,
  input  logic [addr_width-1:0] lsu_awaddr,
  input  logic [id_width-1:0]   lsu_awid,
  input  logic [size_width-1:0] lsu_awsize,
  input  logic                  lsu_wvalid,
  output logic                  lsu_wready,
  input  logic [data_width-1:0] lsu_wdata,
  input  logic [strb_width-1:0] lsu_wstrb,
  input  logic                  lsu_wlast,
  output logic                  lsu_bvalid,
  input  logic                  lsu_bready,
  output logic [resp_width-1:0] lsu_bresp,
  output logic [id_width-1:0]   lsu_bid,
  // external master
  output logic                  io_master_awvalid,
  input  logic                  io_master_awready,
  output logic [addr_width-1:0] io_master_awaddr,
  output logic [id_width-1:0]   io_master_awid,
  output logic [size_width-1:0] io_master_awsize,
  output logic                  io_master_wvalid,
  input  logic                  io_master_wready,
  output logic [data_width-1:0] io_master_wdata,
  output logic [strb_width-1:0] io_master_wstrb,
  output logic                  io_master_wlast,
  input  logic                  io_master_bvalid,
  output logic                  io_master_bready,
  input  logic [resp_width-1:0] io_master_bresp,
  input  logic [id_width-1:0]   io_master_bid,
  output logic                  io_master_arvalid,
  input  logic                  io_master_arready,
  output logic [addr_width-1:0] io_master_araddr,
  output logic [id_width-1:0]   io_master_arid,
  output logic [size_width-1:0] io_master_arsize,
  input  logic                  io_master_rvalid,
  output logic                  io_master_rready,
  input  logic [data_width-1:0] io_master_rdata,
  input  logic [resp_width-1:0] io_master_rresp,
  input  logic                  io_master_rlast,
  input  logic [id_width-1:0]   io_master_rid
);

  mem_rd_if fetch_rd ();
  mem_rd_if lsu_rd ();
  mem_rd_if grant_rd ();
  mem_rd_if clint_rd ();

  assign fetch_rd.arvalid = fetch_arvalid;
  assign fetch_rd.araddr  = fetch_araddr;
  assign fetch_rd.arid    = fetch_arid;
  assign fetch_rd.arsize  = fetch_arsize;
  assign fetch_rd.rready  = fetch_rready;
  assign fetch_arready    = fetch_rd.arready;
  assign fetch_rvalid     = fetch_rd.rvalid;
  assign fetch_rdata      = fetch_rd.rdata;
  assign fetch_rresp      = fetch_rd.rresp;
  assign fetch_rlast      = fetch_rd.rlast;
  assign fetch_rid        = fetch_rd.rid;

  assign lsu_rd.arvalid = lsu_arvalid;
  assign lsu_rd.araddr  = lsu_araddr;
  assign lsu_rd.arid    = lsu_arid;
  assign lsu_rd.arsize  = lsu_arsize;
  assign lsu_rd.rready  = lsu_rready;
  assign lsu_arready    = lsu_rd.arready;
  assign lsu_rvalid     = lsu_rd.rvalid;
  assign lsu_rdata      = lsu_rd.rdata;
  assign lsu_rresp      = lsu_rd.rresp;
  assign lsu_rlast      = lsu_rd.rlast;
  assign lsu_rid        = lsu_rd.rid;

  // write path goes straight out
  assign io_master_awvalid = lsu_awvalid;
  assign io_master_awaddr  = lsu_awaddr;
  assign io_master_awid    = lsu_awid;
  assign io_master_awsize  = lsu_awsize;
  assign io_master_wvalid  = lsu_wvalid;
  assign io_master_wdata   = lsu_wdata;
  assign io_master_wstrb   = lsu_wstrb;
  assign io_master_wlast   = lsu_wlast;
  assign io_master_bready  = lsu_bready;
  assign lsu_awready       = io_master_awready;
  assign lsu_wready        = io_master_wready;
  assign lsu_bvalid        = io_master_bvalid;
  assign lsu_bresp         = io_master_bresp;
  assign lsu_bid           = io_master_bid;

  read_arbiter u_arbiter (
    .clock (clock),
    .rst   (rst),
    .fetch (fetch_rd.slave),
    .lsu   (lsu_rd.slave),
    .grant (grant_rd.master)
  );

  read_router #(
    .clint_base (clint_base)
  ) u_router (
    .clock             (clock),
    .rst               (rst),
    .up                (grant_rd.slave),
    .clint             (clint_rd.master),
    .io_master_arvalid (io_master_arvalid),
    .io_master_arready (io_master_arready),
    .io_master_araddr  (io_master_araddr),
    .io_master_arid    (io_master_arid),
    .io_master_arsize  (io_master_arsize),
    .io_master_rvalid  (io_master_rvalid),
    .io_master_rready  (io_master_rready),
    .io_master_rdata   (io_master_rdata),
    .io_master_rresp   (io_master_rresp),
    .io_master_rlast   (io_master_rlast),
    .io_master_rid     (io_master_rid)
  );

  clint_timer u_clint (
    .clock (clock),
    .rst   (rst),
    .bus   (clint_rd.slave)
  );

endmodule

/* logic/clint_timer.sv */
`timescale 1ns/100ps

module clint_timer import bus_pkg::*; (
  input logic     clock,
  input logic     rst,
  mem_rd_if.slave bus
);

  localparam int off_width = $clog2(clint_size);

  mtime_u                mtime;
  logic [off_width-1:0]  off;
  logic [data_width-1:0] rd_word;
  logic                  rvalid_q;  // one pending response
  logic [data_width-1:0] rdata_q;
  logic [id_width-1:0]   rid_q;

  assign off = bus.araddr[off_width-1:0];

  // word select by offset, anything else reads zero
  always_comb begin
    if (off == mtime_lo_off[off_width-1:0]) begin
      rd_word = mtime.halves.lo;
    end else if (off == mtime_hi_off[off_width-1:0]) begin
      rd_word = mtime.halves.hi;
    end else begin
      rd_word = '0;
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      mtime.count <= '0;
    end else begin
      mtime.count <= mtime.count + 1'b1;  // free running
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      rvalid_q <= 1'b0;
    end else if (bus.arvalid && bus.arready) begin
      rvalid_q <= 1'b1;
    end else if (bus.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (bus.arvalid && bus.arready) begin
      rdata_q <= rd_word;
      rid_q   <= bus.arid;  // id echoed back
    end
  end

  assign bus.arready = !rvalid_q;
  assign bus.rvalid  = rvalid_q;
  assign bus.rdata   = rdata_q;
  assign bus.rid     = rid_q;
  assign bus.rresp   = resp_okay;
  assign bus.rlast   = 1'b1;  // single beat

endmodule

/* logic/read_router.sv */
`timescale 1ns/100ps

module read_router import bus_pkg::*; #(
  parameter logic [addr_width-1:0] clint_base = 32'h0200_0000
) (
  input  logic                  clock,
  input  logic                  rst,
  mem_rd_if.slave               up,
  mem_rd_if.master              clint,
  output logic                  io_master_arvalid,
  input  logic                  io_master_arready,
  output logic [addr_width-1:0] io_master_araddr,
  output logic [id_width-1:0]   io_master_arid,
  output logic [size_width-1:0] io_master_arsize,
  input  logic                  io_master_rvalid,
  output logic                  io_master_rready,
  input  logic [data_width-1:0] io_master_rdata,
  input  logic [resp_width-1:0] io_master_rresp,
  input  logic                  io_master_rlast,
  input  logic [id_width-1:0]   io_master_rid
);

  logic [addr_width-1:0] win_off;
  logic                  in_window;
  logic                  dest_clint;  // destination of the accepted read

  // unsigned wrap covers both window bounds in one compare
  assign win_off   = up.araddr - clint_base;
  assign in_window = win_off < clint_size;

  // address steering, payload goes to both sides
  assign io_master_arvalid = up.arvalid && !in_window;
  assign io_master_araddr  = up.araddr;
  assign io_master_arid    = up.arid;
  assign io_master_arsize  = up.arsize;

  assign clint.arvalid = up.arvalid && in_window;
  assign clint.araddr  = up.araddr;
  assign clint.arid    = up.arid;
  assign clint.arsize  = up.arsize;

  assign up.arready = in_window ? clint.arready : io_master_arready;

  // response mux follows the latched destination
  assign up.rvalid = dest_clint ? clint.rvalid : io_master_rvalid;
  assign up.rdata  = dest_clint ? clint.rdata : io_master_rdata;
  assign up.rresp  = dest_clint ? clint.rresp : io_master_rresp;
  assign up.rlast  = dest_clint ? clint.rlast : io_master_rlast;
  assign up.rid    = dest_clint ? clint.rid : io_master_rid;

  assign clint.rready     = up.rready && dest_clint;
  assign io_master_rready = up.rready && !dest_clint;

  always_ff @(posedge clock) begin
    if (rst) begin
      dest_clint <= 1'b0;
    end else if (up.arvalid && up.arready) begin
      dest_clint <= in_window;  // held until the next accepted address
    end
  end

endmodule

/* logic/read_arbiter.sv */
`timescale 1ns/100ps

module read_arbiter (
  input logic      clock,
  input logic      rst,
  mem_rd_if.slave  fetch,
  mem_rd_if.slave  lsu,
  mem_rd_if.master grant
);

  logic busy;       // owner locked until the last response beat
  logic addr_done;  // address of the current owner already accepted
  logic owner_lsu;
  logic sel_lsu;
  logic ar_open;

  // at idle load/store wins, after that the owner is locked
  assign sel_lsu = busy ? owner_lsu : lsu.arvalid;
  assign ar_open = !(busy && addr_done);  // one address per grant

  // address channel toward the router
  assign grant.arvalid = ar_open && (sel_lsu ? lsu.arvalid : fetch.arvalid);
  assign grant.araddr  = sel_lsu ? lsu.araddr : fetch.araddr;
  assign grant.arid    = sel_lsu ? lsu.arid : fetch.arid;
  assign grant.arsize  = sel_lsu ? lsu.arsize : fetch.arsize;

  // loser sees arready low and keeps waiting
  assign lsu.arready   = ar_open && sel_lsu && grant.arready;
  assign fetch.arready = ar_open && !sel_lsu && grant.arready;

  // response goes back to the owner only
  assign lsu.rvalid   = busy && owner_lsu && grant.rvalid;
  assign fetch.rvalid = busy && !owner_lsu && grant.rvalid;
  assign grant.rready = busy && (owner_lsu ? lsu.rready : fetch.rready);

  assign lsu.rdata   = grant.rdata;
  assign lsu.rresp   = grant.rresp;
  assign lsu.rlast   = grant.rlast;
  assign lsu.rid     = grant.rid;
  assign fetch.rdata = grant.rdata;
  assign fetch.rresp = grant.rresp;
  assign fetch.rlast = grant.rlast;
  assign fetch.rid   = grant.rid;

  always_ff @(posedge clock) begin
    if (rst) begin
      busy      <= 1'b0;
      addr_done <= 1'b0;
      owner_lsu <= 1'b0;
    end else if (!busy) begin
      if (grant.arvalid) begin
        busy      <= 1'b1;
        owner_lsu <= sel_lsu;
        addr_done <= grant.arready;  // may be accepted right away
      end
    end else begin
      if (grant.arvalid && grant.arready) begin
        addr_done <= 1'b1;
      end
      // release after the final beat, idle next cycle
      if (grant.rvalid && grant.rready && grant.rlast) begin
        busy      <= 1'b0;
        addr_done <= 1'b0;
      end
    end
  end

endmodule

/* logic/mem_rd_if.sv */
`timescale 1ns/100ps

// single-beat read channel pair, ar and r
interface mem_rd_if import bus_pkg::*; ();

  logic                  arvalid;
  logic                  arready;
  logic [addr_width-1:0] araddr;
  logic [id_width-1:0]   arid;
  logic [size_width-1:0] arsize;

  logic                  rvalid;
  logic                  rready;
  logic [data_width-1:0] rdata;
  logic [resp_width-1:0] rresp;
  logic                  rlast;
  logic [id_width-1:0]   rid;

  modport master (
    output arvalid, araddr, arid, arsize, rready,
    input  arready, rvalid, rdata, rresp, rlast, rid
  );

  modport slave (
    input  arvalid, araddr, arid, arsize, rready,
    output arready, rvalid, rdata, rresp, rlast, rid
  );

endinterface

/* logic/bus_pkg.sv */
package bus_pkg;

  // bus widths
  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int id_width   = 4;
  localparam int size_width = 3;   // axsize encoding
  localparam int strb_width = 4;   // one strobe per byte lane
  localparam int resp_width = 2;

  // the fabric itself only ever answers okay
  localparam logic [resp_width-1:0] resp_okay = 2'b00;

  // clint window, 64 KB from the base set at the top level
  localparam logic [addr_width-1:0] clint_size = 32'h0001_0000;

  // timer word offsets inside the window
  localparam logic [addr_width-1:0] mtime_lo_off = 32'h0000_BFF8;
  localparam logic [addr_width-1:0] mtime_hi_off = 32'h0000_BFFC;

  // 64-bit machine timer
  // count view for the increment, halves view for the word reads
  typedef union packed {
    logic [2*data_width-1:0] count;
    struct packed {
      logic [data_width-1:0] hi;
      logic [data_width-1:0] lo;
    } halves;
  } mtime_u;

endpackage
